// ==== dv/tbModel.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// True when the bit just accepted closes a block that yields an output
function automatic bit blockCompletes(input int bitsSoFar);
    if (bitsSoFar % dsmPkg::DSR != 0) begin
        return 1'b0;
    end
    return bitsSoFar >= firPkg::TAPS;
endfunction

// Expected offset-binary sample for the block whose newest bit is hist[newest]
function automatic logic [dsmPkg::OUT_W-1:0] expectedSample(
    const ref bit hist[$],
    input int newest
);
    int acc;
    int scaled;
    int limitHi;
    int limitLo;
    logic [dsmPkg::OUT_W-1:0] code;
    acc = 0;
    // Tap k weighs the bit k places older than the newest one
    for (int k = 0; k < firPkg::TAPS; k++) begin
        if (hist[newest - k]) begin
            acc = acc + int'(firPkg::COEFS[k]);
        end else begin
            acc = acc - int'(firPkg::COEFS[k]);
        end
    end
    scaled = acc >>> firPkg::SCALE_SHIFT;
    limitHi = (1 << (dsmPkg::OUT_W - 1)) - 1;
    limitLo = -(1 << (dsmPkg::OUT_W - 1));
    if (scaled > limitHi) begin
        scaled = limitHi;
    end else if (scaled < limitLo) begin
        scaled = limitLo;
    end
    code = scaled[dsmPkg::OUT_W-1:0];
    // Offset binary
    code[dsmPkg::OUT_W-1] = ~code[dsmPkg::OUT_W-1];
    return code;
endfunction

`endif

// ==== dv/tbTop.sv ====
`timescale 1ns/1ps

module tbTop;

    localparam int CLK_HALF = 20;
    localparam int RESET_CYCLES = 8;
    localparam int SEED = 54830;
    localparam int FIRST_LATENCY = 7;
    localparam int STALL_LIMIT = 64;
    localparam int DRAIN_LIMIT = 2000;
    localparam int SETTLE_CYCLES = 12;
    localparam int PAT_RANDOM = 0;
    localparam int PAT_ONES = 1;
    localparam int PAT_ZEROS = 2;

    logic clkDS;
    logic rstN;
    logic bitIn;
    logic bitValid;
    logic bitReady;
    logic [dsmPkg::OUT_W-1:0] sampleOut;
    logic sampleValid;
    logic sampleReady;

    bit history[$];
    logic [dsmPkg::OUT_W-1:0] expQ[$];
    logic [dsmPkg::OUT_W-1:0] expHead = '0;
    logic [dsmPkg::OUT_W-1:0] prevOut = '0;
    int expCount = 0;
    int bitCount = 0;
    int outCount = 0;
    bit stallMode = 1'b0;

    `include "tbModel.svh"

    decimatorTop decimatorTop_i (
        .clkDS       (clkDS),
        .rstN        (rstN),
        .bitIn       (bitIn),
        .bitValid    (bitValid),
        .bitReady    (bitReady),
        .sampleOut   (sampleOut),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady)
    );

    always #(CLK_HALF) clkDS = ~clkDS;

    task automatic stopWithFailure();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic failWith(input string reason);
        $display("ERROR: %s", reason);
        stopWithFailure();
    endtask

    task automatic reportMismatch(
        input string name,
        input logic [dsmPkg::OUT_W-1:0] expected,
        input logic [dsmPkg::OUT_W-1:0] actual
    );
        $display("MISMATCH %s expected 0x%h actual 0x%h", name, expected, actual);
        stopWithFailure();
    endtask

    // Tracks accepted bits, expected samples and taken outputs
    always @(posedge clkDS) begin
        if (!rstN) begin
            history.delete();
            expQ.delete();
            bitCount = 0;
            outCount = 0;
        end else begin
            if (sampleValid && sampleReady) begin
                outCount++;
                if (expQ.size() > 0) begin
                    void'(expQ.pop_front());
                end
            end
            if (bitValid && bitReady) begin
                history.push_back(bitIn);
                bitCount++;
                if (blockCompletes(bitCount)) begin
                    expQ.push_back(expectedSample(history, bitCount - 1));
                end
            end
        end
        expCount = expQ.size();
        expHead = (expQ.size() > 0) ? expQ[0] : '0;
        prevOut = sampleOut;
    end

    // Nothing comes out and nothing stalls while the window fills
    assert property (@(posedge clkDS) disable iff (!rstN)
        bitCount < firPkg::TAPS |-> !sampleValid && bitReady)
        else failWith("output or back-pressure seen before six blocks were accepted");

    assert property (@(posedge clkDS) disable iff (!rstN)
        sampleValid && sampleReady |-> expCount > 0)
        else failWith("sampleOut was taken with no expected sample left");

    assert property (@(posedge clkDS) disable iff (!rstN)
        sampleValid && sampleReady && expCount > 0 |-> sampleOut == expHead)
        else reportMismatch("sampleOut", $sampled(expHead), $sampled(sampleOut));

    assert property (@(posedge clkDS) disable iff (!rstN)
        sampleValid && !sampleReady |=> sampleValid)
        else failWith("sampleValid dropped before its sample was taken");

    assert property (@(posedge clkDS) disable iff (!rstN)
        sampleValid && !sampleReady |=> sampleOut == prevOut)
        else reportMismatch("sampleOut", $sampled(prevOut), $sampled(sampleOut));

    // Last bit of the sixth block to the first sample
    assert property (@(posedge clkDS) disable iff (!rstN)
        bitValid && bitReady && bitCount == firPkg::TAPS - 1 |->
            !sampleValid [*FIRST_LATENCY] ##1 sampleValid)
        else failWith("first sampleValid did not rise 7 cycles after the sixth block");

    function automatic bit nextBit(input int pattern);
        if (pattern == PAT_ONES) begin
            return 1'b1;
        end
        if (pattern == PAT_ZEROS) begin
            return 1'b0;
        end
        return bit'($urandom % 2);
    endfunction

    task automatic driveReady();
        forever begin
            @(posedge clkDS);
            if (stallMode) begin
                sampleReady <= (($urandom % 3) != 0);
            end else begin
                sampleReady <= 1'b1;
            end
        end
    endtask

    task automatic applyReset();
        @(posedge clkDS);
        rstN <= 1'b0;
        bitValid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clkDS);
        rstN <= 1'b1;
    endtask

    task automatic sendBits(input int count, input int pattern, input bit gaps);
        int sent;
        int idle;
        sent = 0;
        idle = 0;
        while (sent < count) begin
            @(posedge clkDS);
            if (bitValid && bitReady) begin
                sent++;
                idle = 0;
            end else begin
                idle++;
            end
            if (idle > STALL_LIMIT) begin
                failWith("no bit was accepted for too many cycles");
            end
            // An offered bit holds until it is taken
            if (!bitValid || bitReady) begin
                if (sent < count && !(gaps && ($urandom % 4) == 0)) begin
                    bitIn <= nextBit(pattern);
                    bitValid <= 1'b1;
                end else begin
                    bitValid <= 1'b0;
                end
            end
        end
    endtask

    task automatic waitDrain();
        int waited;
        waited = 0;
        while (expQ.size() > 0) begin
            if (waited >= DRAIN_LIMIT) begin
                failWith("expected samples never came out of the pipeline");
            end
            @(negedge clkDS);
            waited++;
        end
    endtask

    task automatic runScenario(
        input int count,
        input int pattern,
        input bit gaps,
        input bit stall
    );
        stallMode = stall;
        applyReset();
        sendBits(count, pattern, gaps);
        waitDrain();
        // Room for a stray extra sample to show up
        repeat (SETTLE_CYCLES) @(negedge clkDS);
        assert (outCount == count / dsmPkg::DSR - (firPkg::FILL_BLOCKS - 1))
            else failWith("output count is not the block count minus five");
    endtask

    initial begin
        clkDS = 1'b0;
        rstN = 1'b0;
        bitIn = 1'b0;
        bitValid = 1'b0;
        sampleReady = 1'b1;
        void'($urandom(SEED));
        fork
            driveReady();
        join_none
        runScenario(200, PAT_RANDOM, 1'b0, 1'b0);
        runScenario(64, PAT_ONES, 1'b0, 1'b0);
        runScenario(64, PAT_ZEROS, 1'b0, 1'b0);
        runScenario(200, PAT_RANDOM, 1'b0, 1'b1);
        runScenario(200, PAT_RANDOM, 1'b1, 1'b0);
        runScenario(240, PAT_RANDOM, 1'b1, 1'b1);
        $display("Simulation passed");
        $finish;
    end

endmodule

// ==== logic/adderTree.sv ====
`timescale 1ns/1ps

module adderTree (
    input  logic                             clkDS,
    input  logic                             rstN,
    partialIf.dst                            part,
    output logic                             sumValid,
    input  logic                             sumReady,
    output logic signed [firPkg::SUM_W-1:0]  sum
);

    logic signed [firPkg::SUM_W-1:0] lvl1 [firPkg::NUM_LUTS/2];
    logic signed [firPkg::SUM_W-1:0] lvl2 [2];
    logic signed [firPkg::SUM_W-1:0] lvl3;
    logic valid1;
    logic valid2;
    logic valid3;
    logic last1;
    logic last2;
    logic last3;
    logic advance;
    logic outSeen;

    // Whole tree moves as one, bubbles included
    assign advance = !valid3 || sumReady;
    assign part.ready = advance;

    always_ff @(posedge clkDS) begin
        if (!rstN) begin
            valid1 <= 1'b0;
            valid2 <= 1'b0;
            valid3 <= 1'b0;
        end else if (advance) begin
            valid1 <= part.valid;
            valid2 <= valid1;
            valid3 <= valid2;
        end
    end

    always_ff @(posedge clkDS) begin
        if (advance) begin
            for (int i = 0; i < firPkg::NUM_LUTS/2; i++) begin
                lvl1[i] <= part.sums[2*i] + part.sums[2*i+1];
            end
            lvl2[0] <= lvl1[0] + lvl1[1];
            lvl2[1] <= lvl1[2];
            lvl3 <= lvl2[0] + lvl2[1];
            last1 <= part.last;
            last2 <= last1;
            last3 <= last2;
        end
    end

    assign sumValid = valid3;
    assign sum = lvl3;

    always_ff @(posedge clkDS) begin
        if (!rstN) begin
            outSeen <= 1'b0;
        end else if (sumValid && sumReady) begin
            outSeen <= 1'b1;
        end
    end

    // Exactly the first sum after reset comes from the fill-ending window
    assert property (@(posedge clkDS) disable iff (!rstN)
        sumValid |-> (last3 == !outSeen));

endmodule

// ==== logic/decimIfs.sv ====
`timescale 1ns/1ps

// Window halves from the shift register to the table stage
interface windowIf;
    logic valid;
    logic ready;
    logic [firPkg::LOOKBACK-1:0] lookback;
    logic [firPkg::LOOKAHEAD-1:0] lookahead;

    modport src (
        output valid,
        output lookback,
        output lookahead,
        input  ready
    );

    modport dst (
        input  valid,
        input  lookback,
        input  lookahead,
        output ready
    );
endinterface

// Registered partial sums into the adder tree
interface partialIf;
    logic valid;
    logic ready;
    logic last;
    logic signed [firPkg::SUM_W-1:0] sums [firPkg::NUM_LUTS];

    modport src (
        output valid,
        output last,
        output sums,
        input  ready
    );

    modport dst (
        input  valid,
        input  last,
        input  sums,
        output ready
    );
endinterface

// ==== logic/decimatorTop.sv ====
`timescale 1ns/1ps

module decimatorTop (
    input  logic                        clkDS,
    input  logic                        rstN,
    input  logic                        bitIn,
    input  logic                        bitValid,
    output logic                        bitReady,
    output logic [dsmPkg::OUT_W-1:0]    sampleOut,
    output logic                        sampleValid,
    input  logic                        sampleReady
);

    logic blockValid;
    logic blockReady;
    logic [dsmPkg::DSR-1:0] block;
    logic sumValid;
    logic sumReady;
    logic signed [firPkg::SUM_W-1:0] sum;

    windowIf winBus ();
    partialIf partBus ();

    sampleDeserializer sampleDeserializer_i (
        .clkDS      (clkDS),
        .rstN       (rstN),
        .bitIn      (bitIn),
        .bitValid   (bitValid),
        .bitReady   (bitReady),
        .blockValid (blockValid),
        .blockReady (blockReady),
        .block      (block)
    );

    windowShifter windowShifter_i (
        .clkDS      (clkDS),
        .rstN       (rstN),
        .blockValid (blockValid),
        .blockReady (blockReady),
        .block      (block),
        .win        (winBus.src)
    );

    lutPartialSums lutPartialSums_i (
        .clkDS (clkDS),
        .rstN  (rstN),
        .win   (winBus.dst),
        .part  (partBus.src)
    );

    adderTree adderTree_i (
        .clkDS    (clkDS),
        .rstN     (rstN),
        .part     (partBus.dst),
        .sumValid (sumValid),
        .sumReady (sumReady),
        .sum      (sum)
    );

    outputFormatter outputFormatter_i (
        .clkDS       (clkDS),
        .rstN        (rstN),
        .sumValid    (sumValid),
        .sumReady    (sumReady),
        .sum         (sum),
        .sampleOut   (sampleOut),
        .sampleValid (sampleValid),
        .sampleReady (sampleReady)
    );

endmodule

// ==== logic/dsmPkg.sv ====
package dsmPkg;

    // Input bits per output sample
    localparam int DSR = 4;

    // Bit counter width inside one block
    localparam int BLK_CNT_W = $clog2(DSR + 1);

    // Output sample format
    localparam int OUT_W = 12;
    localparam int OUT_MAX = 2 ** (OUT_W - 1) - 1;
    localparam int OUT_MIN = -(2 ** (OUT_W - 1));

    // Window stage state
    typedef enum logic {
        FILLING = 1'b0,
        RUNNING = 1'b1
    } fillStateT;

endpackage

// ==== logic/firPkg.sv ====
package firPkg;

    // Tap split around the decimation point
    localparam int LOOKBACK = 12;
    localparam int LOOKAHEAD = 12;
    localparam int TAPS = LOOKBACK + LOOKAHEAD;

    // Bits of window per lookup table
    localparam int LUT_SIZE = 4;
    localparam int NUM_LUTS = TAPS / LUT_SIZE;
    localparam int AHEAD_LUTS = LOOKAHEAD / LUT_SIZE;

    localparam int COEF_W = 10;

    // Symmetric low-pass, index 0 is the newest bit
    localparam logic signed [COEF_W-1:0] COEFS [TAPS] = '{
        10'sd30,  10'sd80,  10'sd160, 10'sd250,
        10'sd340, 10'sd410, 10'sd460, 10'sd490,
        10'sd505, 10'sd511, 10'sd511, 10'sd511,
        10'sd511, 10'sd511, 10'sd511, 10'sd505,
        10'sd490, 10'sd460, 10'sd410, 10'sd340,
        10'sd250, 10'sd160, 10'sd80,  10'sd30
    };

    // Coefficient magnitudes total 8516, well inside 16 bits
    localparam int SUM_W = 16;
    localparam int SCALE_SHIFT = 2;

    // Blocks needed before the window holds only real bits
    localparam int FILL_BLOCKS = TAPS / dsmPkg::DSR;
    localparam int FILL_CNT_W = $clog2(FILL_BLOCKS + 1);

endpackage

// ==== logic/lutPartialSums.sv ====
`timescale 1ns/1ps

module lutPartialSums (
    input  logic   clkDS,
    input  logic   rstN,
    windowIf.dst   win,
    partialIf.src  part
);

    // Window tap read by bit j of group g
    function automatic int tapOf(int g, int j);
        if (g < firPkg::AHEAD_LUTS) begin
            return firPkg::LOOKAHEAD - 1 - (g * firPkg::LUT_SIZE + j);
        end
        return firPkg::LOOKAHEAD + (g - firPkg::AHEAD_LUTS) * firPkg::LUT_SIZE + j;
    endfunction

    // Each bit weighs its coefficient as +1 or -1
    function automatic logic signed [firPkg::SUM_W-1:0] lutEntry(int g, int idx);
        int acc;
        acc = 0;
        for (int j = 0; j < firPkg::LUT_SIZE; j++) begin
            if (idx[j]) begin
                acc += int'(firPkg::COEFS[tapOf(g, j)]);
            end else begin
                acc -= int'(firPkg::COEFS[tapOf(g, j)]);
            end
        end
        return firPkg::SUM_W'(acc);
    endfunction

    logic [firPkg::LUT_SIZE-1:0] sel [firPkg::NUM_LUTS];
    logic signed [firPkg::SUM_W-1:0] lutOut [firPkg::NUM_LUTS];
    logic firstPending;
    logic load;

    for (genvar g = 0; g < firPkg::NUM_LUTS; g++) begin : gLut
        logic signed [firPkg::SUM_W-1:0] tbl [2 ** firPkg::LUT_SIZE];

        if (g < firPkg::AHEAD_LUTS) begin : gAhead
            assign sel[g] = win.lookahead[g*firPkg::LUT_SIZE +: firPkg::LUT_SIZE];
        end else begin : gBack
            assign sel[g] =
                win.lookback[(g-firPkg::AHEAD_LUTS)*firPkg::LUT_SIZE +: firPkg::LUT_SIZE];
        end

        for (genvar e = 0; e < 2 ** firPkg::LUT_SIZE; e++) begin : gEntry
            assign tbl[e] = lutEntry(g, e);
        end

        assign lutOut[g] = tbl[sel[g]];
    end

    assign win.ready = !part.valid || part.ready;
    assign load = win.valid && win.ready;

    always_ff @(posedge clkDS) begin
        if (!rstN) begin
            part.valid <= 1'b0;
            firstPending <= 1'b1;
        end else begin
            if (load) begin
                part.valid <= 1'b1;
                firstPending <= 1'b0;
            end else if (part.ready) begin
                part.valid <= 1'b0;
            end
        end
    end

    // First window after reset is the one that ended the fill
    always_ff @(posedge clkDS) begin
        if (load) begin
            part.last <= firstPending;
            for (int g = 0; g < firPkg::NUM_LUTS; g++) begin
                part.sums[g] <= lutOut[g];
            end
        end
    end

endmodule

// ==== logic/outputFormatter.sv ====
`timescale 1ns/1ps

module outputFormatter (
    input  logic                             clkDS,
    input  logic                             rstN,
    input  logic                             sumValid,
    output logic                             sumReady,
    input  logic signed [firPkg::SUM_W-1:0]  sum,
    output logic [dsmPkg::OUT_W-1:0]         sampleOut,
    output logic                             sampleValid,
    input  logic                             sampleReady
);

    logic signed [firPkg::SUM_W-1:0] shifted;
    logic signed [firPkg::SUM_W-1:0] satHi;
    logic signed [firPkg::SUM_W-1:0] satLo;
    logic [dsmPkg::OUT_W-1:0] clipped;
    logic tooHigh;
    logic tooLow;
    logic load;

    assign satHi = firPkg::SUM_W'(dsmPkg::OUT_MAX);
    assign satLo = firPkg::SUM_W'(dsmPkg::OUT_MIN);

    assign shifted = sum >>> firPkg::SCALE_SHIFT;
    assign tooHigh = shifted > satHi;
    assign tooLow = shifted < satLo;

    always_comb begin
        if (tooHigh) begin
            clipped = satHi[dsmPkg::OUT_W-1:0];
        end else if (tooLow) begin
            clipped = satLo[dsmPkg::OUT_W-1:0];
        end else begin
            clipped = shifted[dsmPkg::OUT_W-1:0];
        end
    end

    assign sumReady = !sampleValid || sampleReady;
    assign load = sumValid && sumReady;

    always_ff @(posedge clkDS) begin
        if (!rstN) begin
            sampleValid <= 1'b0;
        end else if (load) begin
            sampleValid <= 1'b1;
        end else if (sampleReady) begin
            sampleValid <= 1'b0;
        end
    end

    // Two's complement to offset binary
    always_ff @(posedge clkDS) begin
        if (load) begin
            sampleOut <= {~clipped[dsmPkg::OUT_W-1], clipped[dsmPkg::OUT_W-2:0]};
        end
    end

    assert property (@(posedge clkDS) disable iff (!rstN)
        load && (tooHigh || tooLow) |=>
            ($past(tooHigh) ? sampleOut == '1 : sampleOut == '0));

endmodule

// ==== logic/sampleDeserializer.sv ====
`timescale 1ns/1ps

module sampleDeserializer (
    input  logic                     clkDS,
    input  logic                     rstN,
    input  logic                     bitIn,
    input  logic                     bitValid,
    output logic                     bitReady,
    output logic                     blockValid,
    input  logic                     blockReady,
    output logic [dsmPkg::DSR-1:0]   block
);

    logic [dsmPkg::BLK_CNT_W-1:0] count;
    logic [dsmPkg::DSR-1:0] blockReg;
    logic bitTaken;
    logic blockTaken;

    assign blockValid = (count == dsmPkg::BLK_CNT_W'(dsmPkg::DSR));
    // A full block may drain and refill in the same cycle
    assign bitReady = !blockValid || blockReady;
    assign block = blockReg;

    assign bitTaken = bitValid && bitReady;
    assign blockTaken = blockValid && blockReady;

    always_ff @(posedge clkDS) begin
        if (!rstN) begin
            count <= '0;
        end else if (bitTaken) begin
            if (blockTaken) begin
                count <= dsmPkg::BLK_CNT_W'(1);
            end else begin
                count <= count + 1'b1;
            end
        end else if (blockTaken) begin
            count <= '0;
        end
    end

    // Newest bit lands in bit 0
    always_ff @(posedge clkDS) begin
        if (bitTaken) begin
            blockReg <= {blockReg[dsmPkg::DSR-2:0], bitIn};
        end
    end

    assert property (@(posedge clkDS) disable iff (!rstN)
        count <= dsmPkg::BLK_CNT_W'(dsmPkg::DSR));

endmodule

// ==== logic/windowShifter.sv ====
`timescale 1ns/1ps

module windowShifter (
    input  logic                    clkDS,
    input  logic                    rstN,
    input  logic                    blockValid,
    output logic                    blockReady,
    input  logic [dsmPkg::DSR-1:0]  block,
    windowIf.src                    win
);

    dsmPkg::fillStateT state;
    logic [firPkg::FILL_CNT_W-1:0] fillCnt;
    logic [firPkg::TAPS-1:0] window;
    logic outValid;
    logic blockTaken;
    logic lastFill;

    assign blockReady = !outValid || win.ready;
    assign blockTaken = blockValid && blockReady;
    assign lastFill = (fillCnt == firPkg::FILL_CNT_W'(firPkg::FILL_BLOCKS - 1));

    always_ff @(posedge clkDS) begin
        if (!rstN) begin
            state <= dsmPkg::FILLING;
            fillCnt <= '0;
            outValid <= 1'b0;
        end else begin
            if (blockTaken && state == dsmPkg::FILLING) begin
                fillCnt <= fillCnt + 1'b1;
                if (lastFill) begin
                    state <= dsmPkg::RUNNING;
                end
            end
            if (blockTaken) begin
                outValid <= (state == dsmPkg::RUNNING) || lastFill;
            end else if (win.ready) begin
                outValid <= 1'b0;
            end
        end
    end

    // Window bit k holds the bit k positions older than the newest
    always_ff @(posedge clkDS) begin
        if (blockTaken) begin
            window <= {window[firPkg::TAPS-dsmPkg::DSR-1:0], block};
        end
    end

    assign win.valid = outValid;
    assign win.lookback = window[firPkg::TAPS-1:firPkg::LOOKAHEAD];

    // Reversed so both halves see mirrored taps in the same order
    always_comb begin
        for (int i = 0; i < firPkg::LOOKAHEAD; i++) begin
            win.lookahead[i] = window[firPkg::LOOKAHEAD-1-i];
        end
    end

    assert property (@(posedge clkDS) disable iff (!rstN)
        win.valid && !win.ready |=>
            win.valid && $stable(win.lookback) && $stable(win.lookahead));

endmodule

// ==== sim.f ====
+incdir+dv
logic/dsmPkg.sv
logic/firPkg.sv
logic/decimIfs.sv
logic/sampleDeserializer.sv
logic/windowShifter.sv
logic/lutPartialSums.sv
logic/adderTree.sv
logic/outputFormatter.sv
logic/decimatorTop.sv
dv/tbTop.sv
